// File: include/riscv_params.svh
`ifndef RISCV_PARAMS_SVH
`define RISCV_PARAMS_SVH

// Data path width
`define XLEN_W 32

// Byte address width of instruction and data memories
`define ADDR_W 12

// PC after reset
`define RESET_PC 32'h0000_0000

// Register index width
`define REG_W 5

`endif

// File: rtl/riscvIsaPkg.sv
`default_nettype none

package riscvIsaPkg;

	// Major opcodes, instr[6:0]
	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OPIMM  = 7'b0010011,
		OPC_OP     = 7'b0110011,
		OPC_SYSTEM = 7'b1110011
	} opcodeT;

	typedef enum logic [2:0] {
		BR_BEQ  = 3'b000,
		BR_BNE  = 3'b001,
		BR_BLT  = 3'b100,
		BR_BGE  = 3'b101,
		BR_BLTU = 3'b110,
		BR_BGEU = 3'b111
	} branchF3T;

	// Load/store widths, U variants load only
	typedef enum logic [2:0] {
		MEM_BYTE  = 3'b000,
		MEM_HALF  = 3'b001,
		MEM_WORD  = 3'b010,
		MEM_BYTEU = 3'b100,
		MEM_HALFU = 3'b101
	} memF3T;

endpackage

`default_nettype wire

// File: rtl/riscvCorePkg.sv
`default_nettype none

package riscvCorePkg;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
		ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
		ALU_PASSB // LUI
	} aluOpT;

	typedef enum logic {A_REG, A_PC} aSelT;

	typedef enum logic {B_REG, B_IMM} bSelT;

	typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_PC4} wbSelT;

	typedef enum logic [1:0] {
		PC_PLUS4,
		PC_BRANCH,
		PC_JAL,
		PC_JALR
	} pcSelT;

endpackage

`default_nettype wire

// File: rtl/control.sv
`timescale 1ns/1ps
`default_nettype none
`include "riscv_params.svh"

module control import riscvIsaPkg::*, riscvCorePkg::*; (
	input wire [`XLEN_W-1:0] instr,
	output aluOpT aluOp,
	output aSelT aSel,
	output bSelT bSel,
	output wbSelT wbSel,
	output pcSelT pcSel,
	output logic regWrite,
	output logic memWrite,
	output logic memRead,
	output logic haltReq
);
	logic [2:0] funct3;
	logic altBit;

	assign funct3 = instr[14:12];
	assign altBit = instr[30]; // SUB / SRA select

	function automatic aluOpT arithOp(input logic [2:0] f3, input logic alt);
		aluOpT op;
		case (f3)
			3'b000: op = alt ? ALU_SUB : ALU_ADD;
			3'b001: op = ALU_SLL;
			3'b010: op = ALU_SLT;
			3'b011: op = ALU_SLTU;
			3'b100: op = ALU_XOR;
			3'b101: op = alt ? ALU_SRA : ALU_SRL;
			3'b110: op = ALU_OR;
			default: op = ALU_AND;
		endcase
		return op;
	endfunction

	always_comb begin
		aluOp = ALU_ADD;
		aSel = A_REG;
		bSel = B_IMM;
		wbSel = WB_ALU;
		pcSel = PC_PLUS4;
		regWrite = 1'b0;
		memWrite = 1'b0;
		memRead = 1'b0;
		haltReq = 1'b0;
		case (opcodeT'(instr[6:0]))
			OPC_LUI: begin
				aluOp = ALU_PASSB;
				regWrite = 1'b1;
			end
			OPC_AUIPC: begin
				aSel = A_PC;
				regWrite = 1'b1;
			end
			OPC_JAL: begin
				pcSel = PC_JAL;
				wbSel = WB_PC4;
				regWrite = 1'b1;
			end
			OPC_JALR: begin
				pcSel = PC_JALR; // Target is rs1 + imm from the ALU
				wbSel = WB_PC4;
				regWrite = 1'b1;
			end
			OPC_BRANCH: begin
				pcSel = PC_BRANCH;
				bSel = B_REG;
			end
			OPC_LOAD: begin
				wbSel = WB_LOAD;
				memRead = 1'b1;
				regWrite = 1'b1;
			end
			OPC_STORE: memWrite = 1'b1;
			OPC_OPIMM: begin
				// Bit 30 is part of the immediate except for SRAI
				aluOp = arithOp(funct3, altBit & (funct3 == 3'b101));
				regWrite = 1'b1;
			end
			OPC_OP: begin
				aluOp = arithOp(funct3, altBit);
				bSel = B_REG;
				regWrite = 1'b1;
			end
			OPC_SYSTEM: haltReq = (funct3 == 3'b000); // ECALL, EBREAK
			default: ; // Unknown opcode, no-op
		endcase
	end

	noRegAndMemWrite: assert final (!(regWrite && memWrite));

endmodule

`default_nettype wire

// File: rtl/immGen.sv
`timescale 1ns/1ps
`default_nettype none
`include "riscv_params.svh"

module immGen import riscvIsaPkg::*; (
	input wire [`XLEN_W-1:0] instr,
	output logic [`XLEN_W-1:0] imm
);

	always_comb begin
		case (opcodeT'(instr[6:0]))
			OPC_LUI, OPC_AUIPC:
				imm = {instr[31:12], 12'b0}; // U
			OPC_JAL:
				imm = {{(`XLEN_W-20){instr[31]}}, instr[19:12], instr[20],
					instr[30:21], 1'b0};
			OPC_BRANCH:
				imm = {{(`XLEN_W-12){instr[31]}}, instr[7], instr[30:25],
					instr[11:8], 1'b0};
			OPC_STORE:
				imm = {{(`XLEN_W-11){instr[31]}}, instr[30:25], instr[11:7]};
			// I format, also loads, JALR and shifts
			default:
				imm = {{(`XLEN_W-11){instr[31]}}, instr[30:20]};
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/alu.sv
`timescale 1ns/1ps
`default_nettype none
`include "riscv_params.svh"

module alu import riscvIsaPkg::*, riscvCorePkg::*; (
	input wire [`XLEN_W-1:0] a,
	input wire [`XLEN_W-1:0] b,
	input wire aluOpT op,
	input wire [2:0] funct3,
	output logic [`XLEN_W-1:0] result,
	output logic branchTaken
);
	logic [4:0] shamt;
	logic lessSigned;
	logic lessUnsigned;

	assign shamt = b[4:0];
	assign lessSigned = $signed(a) < $signed(b);
	assign lessUnsigned = a < b;

	always_comb begin
		case (op)
			ALU_ADD: result = a + b;
			ALU_SUB: result = a - b;
			ALU_SLL: result = a << shamt;
			ALU_SLT: result = {{(`XLEN_W-1){1'b0}}, lessSigned};
			ALU_SLTU: result = {{(`XLEN_W-1){1'b0}}, lessUnsigned};
			ALU_XOR: result = a ^ b;
			ALU_SRL: result = a >> shamt;
			ALU_SRA: result = $signed(a) >>> shamt;
			ALU_OR: result = a | b;
			ALU_AND: result = a & b;
			default: result = b; // PASSB
		endcase
	end

	// Only looked at by pcUnit on branch instructions
	always_comb begin
		case (branchF3T'(funct3))
			BR_BEQ: branchTaken = (a == b);
			BR_BNE: branchTaken = (a != b);
			BR_BLT: branchTaken = lessSigned;
			BR_BGE: branchTaken = !lessSigned;
			BR_BLTU: branchTaken = lessUnsigned;
			BR_BGEU: branchTaken = !lessUnsigned;
			default: branchTaken = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/pcUnit.sv
`timescale 1ns/1ps
`default_nettype none
`include "riscv_params.svh"

module pcUnit import riscvCorePkg::*; (
	input wire CLK,
	input wire RSTn,
	input wire pcSelT pcSel,
	input wire branchTaken,
	input wire [`XLEN_W-1:0] imm,
	input wire [`XLEN_W-1:0] jalrTarget,
	input wire haltReq,
	output logic [`XLEN_W-1:0] pc,
	output logic [`XLEN_W-1:0] pcPlus4,
	output logic halt,
	output logic [`XLEN_W-1:0] numInst
);
	logic haltReg;
	logic [`XLEN_W-1:0] pcNext;
	logic [`XLEN_W-1:0] pcTarget;

	assign pcPlus4 = pc + `XLEN_W'd4;
	assign pcTarget = pc + imm; // Branch and JAL share the adder
	assign halt = haltReg | (haltReq & ~RSTn);

	always_comb begin
		case (pcSel)
			PC_BRANCH: pcNext = branchTaken ? pcTarget : pcPlus4;
			PC_JAL: pcNext = pcTarget;
			PC_JALR: pcNext = {jalrTarget[`XLEN_W-1:1], 1'b0};
			default: pcNext = pcPlus4;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			pc <= `RESET_PC;
			haltReg <= 1'b0;
			numInst <= '0;
		end else begin
			if (haltReq)
				haltReg <= 1'b1; // Sticky until reset
			if (!halt) begin
				pc <= pcNext;
				numInst <= numInst + 1'b1;
			end
		end
	end

	// Targets come from immGen and alu
	pcAligned: assert property (@(posedge CLK) disable iff (RSTn)
		pc[1:0] == 2'b00);

	pcFrozen: assert property (@(posedge CLK) disable iff (RSTn)
		haltReg |=> $stable(pc) && $stable(numInst));

endmodule

`default_nettype wire

// File: rtl/lsu.sv
`timescale 1ns/1ps
`default_nettype none
`include "riscv_params.svh"

module lsu import riscvIsaPkg::*; (
	input wire [1:0] addr,
	input wire [2:0] funct3,
	input wire [`XLEN_W-1:0] storeData,
	input wire [`XLEN_W-1:0] loadRaw,
	input wire memWrite,
	output logic [`XLEN_W/8-1:0] be,
	output logic [`XLEN_W-1:0] dout,
	output logic [`XLEN_W-1:0] loadData
);
	logic [`XLEN_W/8-1:0] mask;
	logic [`XLEN_W-1:0] shifted;

	// Store lanes, data replicated so any offset lines up
	always_comb begin
		case (memF3T'(funct3))
			MEM_BYTE, MEM_BYTEU: begin
				mask = 4'b0001 << addr;
				dout = {4{storeData[7:0]}};
			end
			MEM_HALF, MEM_HALFU: begin
				mask = addr[1] ? 4'b1100 : 4'b0011;
				dout = {2{storeData[15:0]}};
			end
			default: begin
				mask = 4'b1111;
				dout = storeData;
			end
		endcase
	end

	assign be = memWrite ? mask : '0;

	assign shifted = loadRaw >> {addr, 3'b000};

	always_comb begin
		case (memF3T'(funct3))
			MEM_BYTE: loadData = {{(`XLEN_W-8){shifted[7]}}, shifted[7:0]};
			MEM_HALF: loadData = {{(`XLEN_W-16){shifted[15]}}, shifted[15:0]};
			MEM_BYTEU: loadData = {{(`XLEN_W-8){1'b0}}, shifted[7:0]};
			MEM_HALFU: loadData = {{(`XLEN_W-16){1'b0}}, shifted[15:0]};
			default: loadData = loadRaw;
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/RISCV_TOP.sv
`timescale 1ns/1ps
`default_nettype none
`include "riscv_params.svh"

module RISCV_TOP import riscvCorePkg::*; (
	input wire CLK,
	input wire RSTn,

	output logic iMemCsn,
	output logic [`ADDR_W-1:0] iMemAddr, // Byte address
	input wire [`XLEN_W-1:0] iMemDi,

	output logic dMemCsn,
	output logic [`ADDR_W-1:0] dMemAddr, // Byte address
	output logic [`XLEN_W-1:0] dMemDout,
	output logic dMemWen,
	output logic [`XLEN_W/8-1:0] dMemBe,
	input wire [`XLEN_W-1:0] dMemDi,

	output logic rfWe,
	output logic [`REG_W-1:0] rfRa1,
	output logic [`REG_W-1:0] rfRa2,
	output logic [`REG_W-1:0] rfWa,
	output logic [`XLEN_W-1:0] rfWd,
	input wire [`XLEN_W-1:0] rfRd1,
	input wire [`XLEN_W-1:0] rfRd2,

	output logic halt,
	output logic [`XLEN_W-1:0] numInst,
	output logic [`XLEN_W-1:0] outputPort
);
	aluOpT aluOp;
	aSelT aSel;
	bSelT bSel;
	wbSelT wbSel;
	pcSelT pcSel;
	logic regWrite, memWrite, memRead, haltReq;
	logic [`XLEN_W-1:0] imm, aluA, aluB, aluResult;
	logic [`XLEN_W-1:0] pc, pcPlus4, loadData;
	logic branchTaken;
	logic writeEn;
	logic storeEn;

	control u_control (
		.instr(iMemDi), .aluOp(aluOp), .aSel(aSel), .bSel(bSel), .wbSel(wbSel),
		.pcSel(pcSel), .regWrite(regWrite), .memWrite(memWrite), .memRead(memRead),
		.haltReq(haltReq)
	);

	immGen u_immGen (.instr(iMemDi), .imm(imm));

	assign aluA = (aSel == A_PC) ? pc : rfRd1;
	assign aluB = (bSel == B_IMM) ? imm : rfRd2;

	alu u_alu (
		.a(aluA), .b(aluB), .op(aluOp), .funct3(iMemDi[14:12]),
		.result(aluResult), .branchTaken(branchTaken)
	);

	pcUnit u_pcUnit (
		.CLK(CLK), .RSTn(RSTn), .pcSel(pcSel), .branchTaken(branchTaken),
		.imm(imm), .jalrTarget(aluResult), .haltReq(haltReq), .pc(pc),
		.pcPlus4(pcPlus4), .halt(halt), .numInst(numInst)
	);

	// No writes in reset or once halted
	assign writeEn = ~RSTn & ~halt;
	assign storeEn = memWrite & writeEn;

	lsu u_lsu (
		.addr(aluResult[1:0]), .funct3(iMemDi[14:12]), .storeData(rfRd2),
		.loadRaw(dMemDi), .memWrite(storeEn), .be(dMemBe), .dout(dMemDout),
		.loadData(loadData)
	);

	assign iMemCsn = RSTn;
	assign iMemAddr = pc[`ADDR_W-1:0];

	assign dMemCsn = ~((memRead | memWrite) & writeEn);
	assign dMemWen = ~storeEn;
	assign dMemAddr = aluResult[`ADDR_W-1:0];

	assign rfRa1 = iMemDi[19:15];
	assign rfRa2 = iMemDi[24:20];
	assign rfWa = iMemDi[11:7];
	assign rfWe = regWrite & writeEn;

	always_comb begin
		case (wbSel)
			WB_LOAD: rfWd = loadData;
			WB_PC4: rfWd = pcPlus4; // Link address
			default: rfWd = aluResult;
		endcase
	end

	assign outputPort = rfWd;

endmodule

`default_nettype wire

// File: tb/tbMemModel.sv
`timescale 1ns/1ps
`default_nettype none
`include "riscv_params.svh"

module tbMemModel (
	input wire CLK,
	input wire iMemCsn,
	input wire [`ADDR_W-1:0] iMemAddr,
	output logic [`XLEN_W-1:0] iMemDi,
	input wire dMemCsn,
	input wire [`ADDR_W-1:0] dMemAddr,
	input wire [`XLEN_W-1:0] dMemDout,
	input wire dMemWen,
	input wire [`XLEN_W/8-1:0] dMemBe,
	output logic [`XLEN_W-1:0] dMemDi,
	input wire rfWe,
	input wire [`REG_W-1:0] rfRa1,
	input wire [`REG_W-1:0] rfRa2,
	input wire [`REG_W-1:0] rfWa,
	input wire [`XLEN_W-1:0] rfWd,
	output logic [`XLEN_W-1:0] rfRd1,
	output logic [`XLEN_W-1:0] rfRd2
);
	logic [`XLEN_W-1:0] imem [0:1023];
	logic [`XLEN_W-1:0] dmem [0:1023];
	logic [`XLEN_W-1:0] rf [0:31];
	logic [9:0] wIdx;

	initial begin
		for (int i = 0; i < 1024; i++)
			dmem[i] = 32'h5A00_0000 ^ (i * 32'h0001_0207); // Unique per word
		for (int i = 0; i < 32; i++)
			rf[i] = (i == 0) ? '0 : (i * 32'h0F0F_1111) ^ 32'h8000_0003;
	end

	assign wIdx = dMemAddr[`ADDR_W-1:2];
	assign iMemDi = iMemCsn ? '0 : imem[iMemAddr[`ADDR_W-1:2]]; // Deselected reads zero
	assign dMemDi = dmem[wIdx];
	assign rfRd1 = (rfRa1 == '0) ? '0 : rf[rfRa1];
	assign rfRd2 = (rfRa2 == '0) ? '0 : rf[rfRa2];

	always @(posedge CLK) begin
		if (rfWe && rfWa != '0)
			rf[rfWa] <= rfWd;
		if (!dMemCsn && !dMemWen) begin
			if (dMemBe[0]) dmem[wIdx][7:0] <= dMemDout[7:0];
			if (dMemBe[1]) dmem[wIdx][15:8] <= dMemDout[15:8];
			if (dMemBe[2]) dmem[wIdx][23:16] <= dMemDout[23:16];
			if (dMemBe[3]) dmem[wIdx][31:24] <= dMemDout[31:24];
		end
	end

endmodule

`default_nettype wire

// File: tb/tbRiscvTop.sv
`timescale 1ns/1ps
`default_nettype none
`include "riscv_params.svh"

module tbRiscvTop import riscvIsaPkg::*; ();
	logic CLK, RSTn;
	logic iMemCsn, dMemCsn, dMemWen, rfWe, halt;
	logic [`ADDR_W-1:0] iMemAddr, dMemAddr;
	logic [`XLEN_W-1:0] iMemDi, dMemDout, dMemDi, rfWd, rfRd1, rfRd2, numInst, outputPort;
	logic [`XLEN_W/8-1:0] dMemBe;
	logic [`REG_W-1:0] rfRa1, rfRa2, rfWa;
	logic [31:0] seed, pcNow, prevExp, retired;
	logic [6:0] opc;
	logic [2:0] f3;
	logic prevValid, prevFlow;
	int pIdx, cycles;

	RISCV_TOP i_dut (.*);
	tbMemModel i_mem (.*);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	function automatic logic [31:0] immI(input logic [31:0] w);
		return {{20{w[31]}}, w[31:20]};
	endfunction
	function automatic logic [31:0] immS(input logic [31:0] w);
		return {{20{w[31]}}, w[31:25], w[11:7]};
	endfunction
	function automatic logic [31:0] immB(input logic [31:0] w);
		return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
	endfunction
	function automatic logic [31:0] immJ(input logic [31:0] w);
		return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
	endfunction

	function automatic logic [31:0] arith(input logic [2:0] fn, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (fn)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'b0, $signed(a) < $signed(b)};
			3'd3: return {31'b0, a < b};
			3'd4: return a ^ b;
			3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic [31:0] expAlu(input logic [31:0] w, input logic [31:0] r1,
		input logic [31:0] r2, input logic [31:0] pc);
		case (w[6:0])
			OPC_LUI: return {w[31:12], 12'b0};
			OPC_AUIPC: return pc + {w[31:12], 12'b0};
			OPC_OPIMM: return arith(w[14:12], w[30] && w[14:12] == 3'd5, r1, immI(w));
			default: return arith(w[14:12], w[30], r1, r2);
		endcase
	endfunction

	function automatic logic [31:0] expNext(input logic [31:0] w, input logic [31:0] r1,
		input logic [31:0] r2, input logic [31:0] pc);
		logic taken;
		case (w[14:12])
			3'd0: taken = r1 == r2;
			3'd1: taken = r1 != r2;
			3'd4: taken = $signed(r1) < $signed(r2);
			3'd5: taken = $signed(r1) >= $signed(r2);
			3'd6: taken = r1 < r2;
			default: taken = r1 >= r2;
		endcase
		case (w[6:0])
			OPC_BRANCH: return taken ? pc + immB(w) : pc + 4;
			OPC_JAL: return pc + immJ(w);
			OPC_JALR: return (r1 + immI(w)) & ~32'd1;
			default: return pc + 4;
		endcase
	endfunction

	function automatic logic [35:0] expLanes(input logic [1:0] a, input logic [2:0] fn,
		input logic [31:0] d);
		case (fn[1:0])
			2'd0: return {4'b0001 << a, {4{d[7:0]}}};
			2'd1: return {a[1] ? 4'b1100 : 4'b0011, {2{d[15:0]}}};
			default: return {4'b1111, d};
		endcase
	endfunction

	function automatic logic [31:0] expLoad(input logic [31:0] raw, input logic [1:0] a,
		input logic [2:0] fn);
		logic [7:0] b;
		logic [15:0] h;
		b = raw[8*a +: 8];
		h = raw[16*a[1] +: 16];
		case (fn)
			3'd0: return {{24{b[7]}}, b};
			3'd1: return {{16{h[15]}}, h};
			3'd4: return {24'b0, b};
			3'd5: return {16'b0, h};
			default: return raw;
		endcase
	endfunction

	task automatic reportValue(input string name, input logic [63:0] exp,
		input logic [63:0] act);
		$display("ERR %s expected %h actual %h", name, exp, act);
		$display("ERRORS FOUND");
		$fatal(1, "check %s failed", name);
	endtask

	task automatic reportText(input string what);
		$display("%s", what);
		$display("ERRORS FOUND");
		$fatal(1, "check failed");
	endtask

	task automatic emit(input logic [31:0] w);
		i_mem.imem[pIdx] = w;
		pIdx++;
	endtask

	task automatic randomAlu();
		logic [31:0] r, r2;
		logic [4:0] rd;
		logic [2:0] fn;
		logic [11:0] im;
		r = $random(seed);
		r2 = $random(seed);
		fn = r[2:0];
		rd = 5'd2 + 5'(r[15:8] % 8'd30);
		im = r2[11:0];
		case (r[5:4])
			2'd2: begin
				if (fn == 3'd1) im[11:5] = 7'h00;
				if (fn == 3'd5) im[11:5] = r[6] ? 7'h20 : 7'h00;
				emit({im, r[31:27], fn, rd, OPC_OPIMM});
			end
			2'd3: emit({r2[31:12], rd, r[6] ? OPC_LUI : OPC_AUIPC});
			default: emit({(r[6] && (fn == 3'd0 || fn == 3'd5)) ? 7'h20 : 7'h00,
				r[26:22], r[31:27], fn, rd, OPC_OP});
		endcase
	endtask

	task automatic randomMem();
		logic [31:0] r;
		logic [2:0] fn;
		logic [9:0] off;
		r = $random(seed);
		off = r[31:22];
		if (r[0]) begin
			fn = 3'(r[3:1] % 3'd3);
			off = off & ~10'((1 << fn) - 1);
			emit({2'b0, off[9:5], r[20:16], 5'd1, fn, off[4:0], OPC_STORE});
		end else begin
			case (r[3:1] % 3'd5)
				3'd0: fn = 3'd0;
				3'd1: fn = 3'd1;
				3'd2: fn = 3'd2;
				3'd3: fn = 3'd4;
				default: fn = 3'd5;
			endcase
			off = off & ~10'((1 << fn[1:0]) - 1);
			emit({2'b0, off, 5'd1, fn, 5'd2 + 5'(r[15:8] % 8'd30), OPC_LOAD});
		end
	endtask

	task automatic buildProgram();
		logic [31:0] r;
		logic [2:0] bf;
		for (int k = 0; k < 1024; k++)
			i_mem.imem[k] = {12'(k), 5'd0, 3'd0, 5'd0, OPC_SYSTEM}; // Halting word elsewhere
		pIdx = 0;
		emit({12'h400, 5'd0, 3'd0, 5'd1, OPC_OPIMM}); // x1 is the data base
		for (int k = 0; k < 60; k++) begin
			r = $random(seed);
			if (r[3:0] < 4'd7)
				randomAlu();
			else if (r[3:0] < 4'd13)
				randomMem();
			else begin
				case (r[7:4] % 4'd6)
					4'd0: bf = 3'd0;
					4'd1: bf = 3'd1;
					4'd2: bf = 3'd4;
					4'd3: bf = 3'd5;
					4'd4: bf = 3'd6;
					default: bf = 3'd7;
				endcase
				// Forward by 8 over one filler
				emit({7'b0, r[20:16], r[25:21], bf, 5'b01000, OPC_BRANCH});
				randomAlu();
			end
		end
		emit({1'b0, 10'd4, 1'b0, 8'd0, 5'd5, OPC_JAL});
		randomAlu();
		emit({12'((pIdx + 3) * 4), 5'd0, 3'd0, 5'd4, OPC_OPIMM});
		emit({12'd0, 5'd4, 3'd0, 5'd6, OPC_JALR});
		randomAlu();
		emit(32'h0000_0073);
	endtask

	assign pcNow = {{(`XLEN_W-`ADDR_W){1'b0}}, iMemAddr};
	assign opc = iMemDi[6:0];
	assign f3 = iMemDi[14:12];

	always @(negedge CLK) begin
		if (RSTn || halt)
			prevValid <= 1'b0;
		else begin
			prevValid <= 1'b1;
			prevExp <= expNext(iMemDi, rfRd1, rfRd2, pcNow);
			prevFlow <= opc == OPC_BRANCH || opc == OPC_JAL || opc == OPC_JALR;
		end
		if (RSTn)
			retired <= '0;
		else if (!halt)
			retired <= retired + 1;
	end

	resetState: assert property (@(negedge CLK) RSTn |->
		iMemAddr == '0 && numInst == '0 && !rfWe && dMemWen && !halt && iMemCsn && dMemCsn)
		else reportText("Outputs are wrong while reset is applied");
	firstFetch: assert property (@(negedge CLK) !RSTn && $past(RSTn) |->
		iMemAddr == '0 && numInst == '0 && !halt)
		else reportText("First instruction is not fetched from the reset PC");
	decodeFields: assert property (@(negedge CLK) disable iff (RSTn)
		{iMemCsn, rfRa1, rfRa2} == {1'b0, iMemDi[19:15], iMemDi[24:20]} &&
		(!rfWe || rfWa == iMemDi[11:7]))
		else reportValue("decodeFields",
			$sampled({1'b0, iMemDi[19:15], iMemDi[24:20], iMemDi[11:7]}),
			$sampled({iMemCsn, rfRa1, rfRa2, rfWa}));
	seqFlow: assert property (@(negedge CLK) disable iff (RSTn)
		prevValid && !prevFlow |-> iMemAddr == prevExp[`ADDR_W-1:0])
		else reportValue("seqFlow", $sampled(prevExp), $sampled(pcNow));
	ctrlFlow: assert property (@(negedge CLK) disable iff (RSTn)
		prevValid && prevFlow |-> iMemAddr == prevExp[`ADDR_W-1:0])
		else reportValue("ctrlFlow", $sampled(prevExp), $sampled(pcNow));
	aluWb: assert property (@(negedge CLK) disable iff (RSTn)
		!halt && (opc == OPC_OP || opc == OPC_OPIMM || opc == OPC_LUI || opc == OPC_AUIPC)
		|-> rfWe && {rfWd, outputPort} == {2{expAlu(iMemDi, rfRd1, rfRd2, pcNow)}})
		else reportValue("aluWb", $sampled({2{expAlu(iMemDi, rfRd1, rfRd2, pcNow)}}),
			$sampled({rfWd, outputPort}));
	linkWb: assert property (@(negedge CLK) disable iff (RSTn)
		!halt && (opc == OPC_JAL || opc == OPC_JALR) |->
		rfWe && {rfWd, outputPort} == {2{pcNow + 32'd4}})
		else reportValue("linkWb", $sampled({2{pcNow + 32'd4}}), $sampled({rfWd, outputPort}));
	storeAddr: assert property (@(negedge CLK) disable iff (RSTn)
		!halt && opc == OPC_STORE |-> !dMemWen && !dMemCsn && !rfWe &&
		dMemAddr == 12'(rfRd1 + immS(iMemDi)))
		else reportValue("storeAddr", $sampled(12'(rfRd1 + immS(iMemDi))), $sampled(dMemAddr));
	storeLanes: assert property (@(negedge CLK) disable iff (RSTn)
		!halt && opc == OPC_STORE |-> {dMemBe, dMemDout} == expLanes(dMemAddr[1:0], f3, rfRd2))
		else reportValue("storeLanes", $sampled(expLanes(dMemAddr[1:0], f3, rfRd2)),
			$sampled({dMemBe, dMemDout}));
	loadWb: assert property (@(negedge CLK) disable iff (RSTn)
		!halt && opc == OPC_LOAD |-> rfWe && dMemWen && !dMemCsn &&
		dMemAddr == 12'(rfRd1 + immI(iMemDi)) &&
		{rfWd, outputPort} == {2{expLoad(dMemDi, dMemAddr[1:0], f3)}})
		else reportValue("loadWb", $sampled({2{expLoad(dMemDi, dMemAddr[1:0], f3)}}),
			$sampled({rfWd, outputPort}));
	haltFreeze: assert property (@(negedge CLK) disable iff (RSTn)
		halt |=> halt && $stable(iMemAddr) && $stable(numInst))
		else reportText("Halt did not freeze the PC and counter");
	haltNoWrite: assert property (@(negedge CLK) disable iff (RSTn)
		halt |-> !rfWe && dMemWen)
		else reportText("A write happened while halted");
	instCount: assert property (@(negedge CLK) !RSTn |-> numInst == retired)
		else reportValue("instCount", $sampled(retired), $sampled(numInst));

	initial begin
		seed = 32'h32796683;
		RSTn = 1'b1;
		buildProgram();
		repeat (3) @(posedge CLK);
		RSTn <= 1'b0;
		cycles = 0;
		while (!halt && cycles < 2000) begin
			@(negedge CLK);
			cycles++;
		end
		if (halt) begin
			repeat (4) @(posedge CLK); // Let the halt checks run
			$display("NO ERRORS");
			$finish;
		end else begin
			$display("ERRORS FOUND");
			$fatal(1, "timeout while waiting for halt");
		end
	end

endmodule

`default_nettype wire

// File: sim.f
+incdir+include
rtl/riscvIsaPkg.sv
rtl/riscvCorePkg.sv
rtl/control.sv
rtl/immGen.sv
rtl/alu.sv
rtl/pcUnit.sv
rtl/lsu.sv
rtl/RISCV_TOP.sv
tb/tbMemModel.sv
tb/tbRiscvTop.sv

// File: Bender.yml
package:
  name: riscv_core

export_include_dirs:
  - include

sources:
  - rtl/riscvIsaPkg.sv
  - rtl/riscvCorePkg.sv
  - rtl/control.sv
  - rtl/immGen.sv
  - rtl/alu.sv
  - rtl/pcUnit.sv
  - rtl/lsu.sv
  - rtl/RISCV_TOP.sv
  - target: test
    files:
      - tb/tbMemModel.sv
      - tb/tbRiscvTop.sv
